// File: ctrlPkg.sv
package ctrlPkg;

	localparam int opcodeWidth = 6;
	localparam int aluOpWidth = 5;

	// encodings fixed by the ISA
	typedef enum logic [opcodeWidth-1:0]
	{
		add = 6'd0,
		addi = 6'd1,
		sub = 6'd2,
		subi = 6'd3,
		mult = 6'd4,
		multi = 6'd5,
		div = 6'd6,
		divi = 6'd7,
		rdiv = 6'd8,
		opOr = 6'd9,
		opAnd = 6'd10,
		opNot = 6'd11,
		opXor = 6'd12,
		opNor = 6'd13,
		opNand = 6'd14,
		opXnor = 6'd15,
		opLt = 6'd16,
		jump = 6'd17,
		jumpR = 6'd18,
		jal = 6'd19,
		beq = 6'd20,
		bne = 6'd21,
		blt = 6'd22,
		lw = 6'd23,
		sw = 6'd24,
		mov = 6'd25,
		movi = 6'd26,
		mfhi = 6'd27,
		mflo = 6'd28,
		opIn = 6'd29,
		opOut = 6'd30,
		spc = 6'd38,
		fim = 6'd63
	} opcodeT;

	typedef enum logic [aluOpWidth-1:0]
	{
		aluAdd = 5'd0,
		aluSub = 5'd1,
		aluMul = 5'd2,
		aluDiv = 5'd3,
		aluRdiv = 5'd4,
		aluOr = 5'd5,
		aluAnd = 5'd6,
		aluNot = 5'd7,
		aluXor = 5'd8,
		aluNor = 5'd9,
		aluNand = 5'd10,
		aluXnor = 5'd11,
		aluLt = 5'd14 // 12 and 13 unused by the ALU
	} aluOpT;

	// write-back source mux select
	typedef enum logic [2:0]
	{
		srcHilo = 3'd0,
		srcAlu = 3'd1,
		srcReg = 3'd2,
		srcMem = 3'd3,
		srcInput = 3'd4,
		srcImm = 3'd5,
		srcPc = 3'd6
	} regSrcT;

	typedef enum logic [1:0]
	{
		ioNone = 2'd0,
		ioOut = 2'd1,
		ioIn = 2'd2
	} ioCtrlT;

endpackage

// File: execDecoder.sv
module execDecoder import ctrlPkg::*;
(
	input logic [opcodeWidth-1:0] opcode,
	output logic execKnown,
	output aluOpT execAluOp,
	output logic execUseImm,
	output logic execRegWrite,
	output regSrcT execRegSrc,
	output logic execMemWrite,
	output logic execHiloSel
);

	always_comb
	begin
		execKnown = 1'b0;
		execAluOp = aluAdd;
		execUseImm = 1'b0;
		execRegWrite = 1'b0;
		execRegSrc = srcHilo;
		execMemWrite = 1'b0;
		execHiloSel = 1'b0;

		case (opcode)
			add, addi, sub, subi, mult, multi, div, divi, rdiv,
			opOr, opAnd, opNot, opXor, opNor, opNand, opXnor, opLt:
			begin
				execKnown = 1'b1;
				execRegWrite = 1'b1;
				execRegSrc = srcAlu;
				case (opcode)
					sub, subi: execAluOp = aluSub;
					mult, multi: execAluOp = aluMul;
					div, divi: execAluOp = aluDiv;
					rdiv: execAluOp = aluRdiv;
					opOr: execAluOp = aluOr;
					opAnd: execAluOp = aluAnd;
					opNot: execAluOp = aluNot;
					opXor: execAluOp = aluXor;
					opNor: execAluOp = aluNor;
					opNand: execAluOp = aluNand;
					opXnor: execAluOp = aluXnor;
					opLt: execAluOp = aluLt;
					default: execAluOp = aluAdd; // add, addi
				endcase
				execUseImm = (opcode == addi) || (opcode == subi) ||
					(opcode == multi) || (opcode == divi);
			end
			beq, bne:
			begin
				execKnown = 1'b1;
				execAluOp = aluSub; // compare by subtraction
			end
			blt:
			begin
				execKnown = 1'b1;
				execAluOp = aluLt;
			end
			lw:
			begin
				execKnown = 1'b1;
				execUseImm = 1'b1;
				execRegWrite = 1'b1;
				execRegSrc = srcMem;
				execAluOp = aluMul;
			end
			sw:
			begin
				execKnown = 1'b1;
				execUseImm = 1'b1;
				execMemWrite = 1'b1;
				execAluOp = aluMul;
			end
			mov, movi:
			begin
				execKnown = 1'b1;
				execRegWrite = 1'b1;
				execRegSrc = (opcode == movi) ? srcImm : srcReg;
			end
			mfhi, mflo:
			begin
				execKnown = 1'b1;
				execRegWrite = 1'b1;
				execHiloSel = (opcode == mfhi); // 1 picks HI
			end
			opIn:
			begin
				execKnown = 1'b1;
				execRegWrite = 1'b1;
				execRegSrc = srcInput;
				execAluOp = aluMul;
			end
			opOut:
			begin
				execKnown = 1'b1;
				execUseImm = 1'b1;
				execAluOp = aluMul;
			end
			default:
			begin
				execKnown = 1'b0; // flow-only or unknown opcode
			end
		endcase
	end

endmodule

// File: sequenceDecoder.sv
module sequenceDecoder import ctrlPkg::*;
(
	input logic [opcodeWidth-1:0] opcode,
	output logic seqKnown,
	output logic seqJump,
	output logic seqJumpReg,
	output logic seqLink,
	output logic seqBranch,
	output logic seqBranchNe,
	output ioCtrlT seqIo,
	output logic seqIoWait,
	output logic seqEnd
);

	always_comb
	begin
		seqKnown = 1'b0;
		seqJump = 1'b0;
		seqJumpReg = 1'b0;
		seqLink = 1'b0;
		seqBranch = 1'b0;
		seqBranchNe = 1'b0;
		seqIo = ioNone;
		seqIoWait = 1'b0;
		seqEnd = 1'b0;

		case (opcode)
			jump, jumpR, jal:
			begin
				seqKnown = 1'b1;
				seqJump = 1'b1;
				seqJumpReg = (opcode == jumpR); // target from register
				seqLink = (opcode == jal);
			end
			spc:
			begin
				seqKnown = 1'b1;
				seqLink = 1'b1; // saves pc without jumping
			end
			beq, bne, blt:
			begin
				seqKnown = 1'b1;
				seqBranch = 1'b1;
				seqBranchNe = (opcode != beq); // blt shares the bne sense
			end
			opIn:
			begin
				seqKnown = 1'b1;
				seqIo = ioIn;
				seqIoWait = 1'b1; // stall until input arrives
			end
			opOut:
			begin
				seqKnown = 1'b1;
				seqIo = ioOut;
			end
			fim:
			begin
				seqKnown = 1'b1;
				seqEnd = 1'b1;
			end
			default:
			begin
				seqKnown = 1'b0;
			end
		endcase
	end

endmodule

// File: decodeStage.sv
module decodeStage import ctrlPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic execKnown,
	input aluOpT execAluOp,
	input logic execUseImm,
	input logic execRegWrite,
	input regSrcT execRegSrc,
	input logic execMemWrite,
	input logic execHiloSel,
	input logic seqKnown,
	input logic seqJump,
	input logic seqJumpReg,
	input logic seqLink,
	input logic seqBranch,
	input logic seqBranchNe,
	input ioCtrlT seqIo,
	input logic seqIoWait,
	input logic seqEnd,
	output aluOpT aluOp,
	output logic useImm,
	output logic regWrite,
	output regSrcT regSrc,
	output logic memWrite,
	output logic hiloSel,
	output logic jump,
	output logic jumpReg,
	output logic link,
	output logic branch,
	output logic branchNe,
	output ioCtrlT io,
	output logic ioWait,
	output logic endProcess,
	output logic illegalOp
);

	logic legal;
	logic nextRegWrite;
	regSrcT nextRegSrc;

	assign legal = execKnown || seqKnown;
	assign nextRegWrite = execRegWrite || seqLink; // link writes the return address
	assign nextRegSrc = seqLink ? srcPc : execRegSrc;

	always_ff @(posedge clk)
	begin
		if (!rstN || !legal)
		begin
			aluOp <= aluAdd;
			useImm <= 1'b0;
			regWrite <= 1'b0;
			regSrc <= srcHilo;
			memWrite <= 1'b0;
			hiloSel <= 1'b0;
			jump <= 1'b0;
			jumpReg <= 1'b0;
			link <= 1'b0;
			branch <= 1'b0;
			branchNe <= 1'b0;
			io <= ioNone;
			ioWait <= 1'b0;
			endProcess <= 1'b0;
			illegalOp <= rstN; // flagged only outside reset
		end
		else
		begin
			aluOp <= execAluOp;
			useImm <= execUseImm;
			regWrite <= nextRegWrite;
			regSrc <= nextRegSrc;
			memWrite <= execMemWrite;
			hiloSel <= execHiloSel;
			jump <= seqJump;
			jumpReg <= seqJumpReg;
			link <= seqLink;
			branch <= seqBranch;
			branchNe <= seqBranchNe;
			io <= seqIo;
			ioWait <= seqIoWait;
			endProcess <= seqEnd;
			illegalOp <= 1'b0;
		end
	end

endmodule

// File: controlUnit.sv
module controlUnit import ctrlPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic [opcodeWidth-1:0] opcode,
	output aluOpT aluOp,
	output logic useImm,
	output logic regWrite,
	output regSrcT regSrc,
	output logic memWrite,
	output logic hiloSel,
	output logic jump,
	output logic jumpReg,
	output logic link,
	output logic branch,
	output logic branchNe,
	output ioCtrlT io,
	output logic ioWait,
	output logic endProcess,
	output logic illegalOp
);

	logic execKnown;
	aluOpT execAluOp;
	logic execUseImm;
	logic execRegWrite;
	regSrcT execRegSrc;
	logic execMemWrite;
	logic execHiloSel;
	logic seqKnown;
	logic seqJump;
	logic seqJumpReg;
	logic seqLink;
	logic seqBranch;
	logic seqBranchNe;
	ioCtrlT seqIo;
	logic seqIoWait;
	logic seqEnd;

	execDecoder execDec
	(
		.opcode(opcode),
		.execKnown(execKnown),
		.execAluOp(execAluOp),
		.execUseImm(execUseImm),
		.execRegWrite(execRegWrite),
		.execRegSrc(execRegSrc),
		.execMemWrite(execMemWrite),
		.execHiloSel(execHiloSel)
	);

	sequenceDecoder seqDec
	(
		.opcode(opcode),
		.seqKnown(seqKnown),
		.seqJump(seqJump),
		.seqJumpReg(seqJumpReg),
		.seqLink(seqLink),
		.seqBranch(seqBranch),
		.seqBranchNe(seqBranchNe),
		.seqIo(seqIo),
		.seqIoWait(seqIoWait),
		.seqEnd(seqEnd)
	);

	decodeStage stage
	(
		.clk(clk),
		.rstN(rstN),
		.execKnown(execKnown),
		.execAluOp(execAluOp),
		.execUseImm(execUseImm),
		.execRegWrite(execRegWrite),
		.execRegSrc(execRegSrc),
		.execMemWrite(execMemWrite),
		.execHiloSel(execHiloSel),
		.seqKnown(seqKnown),
		.seqJump(seqJump),
		.seqJumpReg(seqJumpReg),
		.seqLink(seqLink),
		.seqBranch(seqBranch),
		.seqBranchNe(seqBranchNe),
		.seqIo(seqIo),
		.seqIoWait(seqIoWait),
		.seqEnd(seqEnd),
		.aluOp(aluOp),
		.useImm(useImm),
		.regWrite(regWrite),
		.regSrc(regSrc),
		.memWrite(memWrite),
		.hiloSel(hiloSel),
		.jump(jump),
		.jumpReg(jumpReg),
		.link(link),
		.branch(branch),
		.branchNe(branchNe),
		.io(io),
		.ioWait(ioWait),
		.endProcess(endProcess),
		.illegalOp(illegalOp)
	);

endmodule

// File: controlUnit_properties.sv
module decodeStageProperties import ctrlPkg::*;
(
	input logic clk,
	input logic rstN,
	input aluOpT aluOp,
	input logic useImm,
	input logic regWrite,
	input regSrcT regSrc,
	input logic memWrite,
	input logic hiloSel,
	input logic jump,
	input logic jumpReg,
	input logic link,
	input logic branch,
	input logic branchNe,
	input ioCtrlT io,
	input logic ioWait,
	input logic endProcess,
	input logic illegalOp
);

	timeunit 1ns;
	timeprecision 100ps;

	illegalNoWrite: assert property (@(posedge clk) illegalOp |-> !regWrite && !memWrite)
		else $error("illegal opcode still writes a register or memory");

	linkWritesPc: assert property (@(posedge clk) link |-> regWrite && regSrc == srcPc)
		else $error("link without a pc write-back");

	// one edge in reset clears everything
	resetClears: assert property (@(posedge clk) !rstN |=> {aluOp, useImm, regWrite, regSrc,
		memWrite, hiloSel, jump, jumpReg, link, branch, branchNe, io, ioWait, endProcess,
		illegalOp} == '0)
		else $error("outputs not zero after a reset cycle");

endmodule

bind decodeStage decodeStageProperties props (.*);

// File: tbControlUnit.sv
module tbControlUnit import ctrlPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int resetCycles = 5;
	localparam int watchdogCycles = 2000;
	localparam int randomCount = 400;
	localparam int keptCount = 33;

	// field order follows the DUT output list
	typedef struct packed
	{
		aluOpT aluOp;
		logic useImm;
		logic regWrite;
		regSrcT regSrc;
		logic memWrite;
		logic hiloSel;
		logic jump;
		logic jumpReg;
		logic link;
		logic branch;
		logic branchNe;
		ioCtrlT io;
		logic ioWait;
		logic endProcess;
		logic illegalOp;
	} ctrlT;

	logic clk;
	logic rstN;
	logic [opcodeWidth-1:0] opcode;
	aluOpT aluOpQ;
	logic useImmQ;
	logic regWriteQ;
	regSrcT regSrcQ;
	logic memWriteQ;
	logic hiloSelQ;
	logic jumpQ;
	logic jumpRegQ;
	logic linkQ;
	logic branchQ;
	logic branchNeQ;
	ioCtrlT ioQ;
	logic ioWaitQ;
	logic endProcessQ;
	logic illegalOpQ;
	ctrlT got;

	int seed = 31;
	int testErrors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int mismatches = 0;
	logic [opcodeWidth-1:0] stimQ[$];

	opcodeT keptOps [keptCount] = '{add, addi, sub, subi, mult, multi, div, divi, rdiv,
		opOr, opAnd, opNot, opXor, opNor, opNand, opXnor, opLt, jump, jumpR, jal, beq, bne,
		blt, lw, sw, mov, movi, mfhi, mflo, opIn, opOut, spc, fim};

	controlUnit dut
	(
		.clk(clk),
		.rstN(rstN),
		.opcode(opcode),
		.aluOp(aluOpQ),
		.useImm(useImmQ),
		.regWrite(regWriteQ),
		.regSrc(regSrcQ),
		.memWrite(memWriteQ),
		.hiloSel(hiloSelQ),
		.jump(jumpQ),
		.jumpReg(jumpRegQ),
		.link(linkQ),
		.branch(branchQ),
		.branchNe(branchNeQ),
		.io(ioQ),
		.ioWait(ioWaitQ),
		.endProcess(endProcessQ),
		.illegalOp(illegalOpQ)
	);

	assign got = {aluOpQ, useImmQ, regWriteQ, regSrcQ, memWriteQ, hiloSelQ, jumpQ, jumpRegQ,
		linkQ, branchQ, branchNeQ, ioQ, ioWaitQ, endProcessQ, illegalOpQ};

	always #5 clk = ~clk;

	function automatic logic isKept(input logic [opcodeWidth-1:0] op);
		logic found;
		found = 1'b0;
		foreach (keptOps[i])
		begin
			if (keptOps[i] == op)
				found = 1'b1;
		end
		return found;
	endfunction

	// expected controls straight from the decode tables
	function automatic ctrlT modelOf(input logic [opcodeWidth-1:0] op);
		ctrlT e;
		e = '0;
		if (!isKept(op))
			e.illegalOp = 1'b1; // everything else stays zero
		else
		begin
			case (op)
				sub, subi, beq, bne: e.aluOp = aluSub;
				mult, multi, lw, sw, opIn, opOut: e.aluOp = aluMul;
				div, divi: e.aluOp = aluDiv;
				rdiv: e.aluOp = aluRdiv;
				opOr: e.aluOp = aluOr;
				opAnd: e.aluOp = aluAnd;
				opNot: e.aluOp = aluNot;
				opXor: e.aluOp = aluXor;
				opNor: e.aluOp = aluNor;
				opNand: e.aluOp = aluNand;
				opXnor: e.aluOp = aluXnor;
				opLt, blt: e.aluOp = aluLt;
				default: e.aluOp = aluAdd;
			endcase
			case (op)
				add, addi, sub, subi, mult, multi, div, divi, rdiv,
				opOr, opAnd, opNot, opXor, opNor, opNand, opXnor, opLt: e.regSrc = srcAlu;
				lw: e.regSrc = srcMem;
				mov: e.regSrc = srcReg;
				movi: e.regSrc = srcImm;
				opIn: e.regSrc = srcInput;
				jal, spc: e.regSrc = srcPc; // link saves the pc
				default: e.regSrc = srcHilo;
			endcase
			e.regWrite = (e.regSrc != srcHilo) || (op inside {mfhi, mflo});
			e.useImm = op inside {addi, subi, multi, divi, lw, sw, opOut};
			e.memWrite = (op == sw);
			e.hiloSel = (op == mfhi);
			e.jump = op inside {jump, jumpR, jal};
			e.jumpReg = (op == jumpR);
			e.link = op inside {jal, spc};
			e.branch = op inside {beq, bne, blt};
			e.branchNe = op inside {bne, blt};
			e.io = (op == opIn) ? ioIn : ((op == opOut) ? ioOut : ioNone);
			e.ioWait = (op == opIn);
			e.endProcess = (op == fim);
		end
		return e;
	endfunction

	task automatic checkField(input string name, input logic [opcodeWidth-1:0] op,
		input logic [31:0] gotV, input logic [31:0] expV);
		if (gotV !== expV)
		begin
			$display("Mismatch at %0t ns: %s for opcode %0d is %0d, expected %0d",
				$time, name, op, gotV, expV);
			mismatches++;
			testErrors++;
		end
	endtask

	task automatic checkOutputs(input logic [opcodeWidth-1:0] op, input ctrlT e);
		checkField("aluOp", op, 32'(got.aluOp), 32'(e.aluOp));
		checkField("useImm", op, 32'(got.useImm), 32'(e.useImm));
		checkField("regWrite", op, 32'(got.regWrite), 32'(e.regWrite));
		checkField("regSrc", op, 32'(got.regSrc), 32'(e.regSrc));
		checkField("memWrite", op, 32'(got.memWrite), 32'(e.memWrite));
		checkField("hiloSel", op, 32'(got.hiloSel), 32'(e.hiloSel));
		checkField("jump", op, 32'(got.jump), 32'(e.jump));
		checkField("jumpReg", op, 32'(got.jumpReg), 32'(e.jumpReg));
		checkField("link", op, 32'(got.link), 32'(e.link));
		checkField("branch", op, 32'(got.branch), 32'(e.branch));
		checkField("branchNe", op, 32'(got.branchNe), 32'(e.branchNe));
		checkField("io", op, 32'(got.io), 32'(e.io));
		checkField("ioWait", op, 32'(got.ioWait), 32'(e.ioWait));
		checkField("endProcess", op, 32'(got.endProcess), 32'(e.endProcess));
		checkField("illegalOp", op, 32'(got.illegalOp), 32'(e.illegalOp));
	endtask

	// back-to-back opcodes checked one edge later
	task automatic runStream();
		ctrlT pending;
		logic [opcodeWidth-1:0] pendingOp;
		int n;
		n = stimQ.size();
		pending = '0;
		pendingOp = '0;
		for (int i = 0; i <= n; i++)
		begin
			@(posedge clk);
			#1;
			if (i > 0)
				checkOutputs(pendingOp, pending);
			if (i < n)
			begin
				opcode = stimQ[i];
				pendingOp = stimQ[i];
				pending = modelOf(stimQ[i]);
			end
		end
		stimQ.delete();
	endtask

	task automatic fillRandom(input int count);
		int pick;
		int value;
		int idx;
		for (int i = 0; i < count; i++)
		begin
			pick = $random(seed);
			value = $random(seed);
			idx = $unsigned(value) % keptCount;
			if (pick[0])
				stimQ.push_back(keptOps[idx]);
			else
				stimQ.push_back(value[opcodeWidth-1:0]); // raw, often illegal
		end
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (testErrors == 0)
			$display("%s: passed", name);
		else
		begin
			testsFailed++;
			$display("%s: failed with %0d errors", name, testErrors);
		end
		testErrors = 0;
	endtask

	task automatic applyReset();
		int cyc;
		logic cleared;
		cyc = 0;
		cleared = 1'b0;
		rstN = 1'b0;
		opcode = 6'd40; // illegal opcode held through reset
		while (!cleared && cyc < resetCycles)
		begin
			@(posedge clk);
			#1;
			cyc++;
			cleared = (got === '0);
		end
		if (!cleared)
		begin
			$display("reset did not clear the outputs within %0d cycles", resetCycles);
			testErrors++;
		end
		while (cyc < resetCycles)
		begin
			@(posedge clk);
			#1;
			cyc++;
		end
		checkOutputs(opcode, '0);
		rstN = 1'b1;
	endtask

	initial
	begin
		clk = 1'b0;
		applyReset();
		finishTest("reset");
		stimQ = '{add, addi, sub, subi, mult, multi, div, divi, rdiv,
			opOr, opAnd, opNot, opXor, opNor, opNand, opXnor, opLt};
		runStream();
		finishTest("arithmetic and logic");
		stimQ = '{jump, jumpR, jal, spc, beq, bne, blt};
		runStream();
		finishTest("flow");
		stimQ = '{lw, sw, mov, movi, mfhi, mflo, opIn, opOut, fim};
		runStream();
		finishTest("memory, moves, hi/lo and io");
		for (int i = 0; i < 64; i++)
		begin
			if (!isKept(6'(i)))
				stimQ.push_back(6'(i));
		end
		runStream();
		finishTest("illegal opcodes");
		fillRandom(randomCount);
		runStream();
		finishTest("random stream");
		$display("%0d tests run, %0d failed, %0d mismatches", testsRun, testsFailed, mismatches);
		if (testsFailed == 0 && mismatches == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial
	begin
		for (int wd = 0; wd < watchdogCycles; wd++)
			@(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", watchdogCycles);
		$display("Test FAILED");
		$finish;
	end

endmodule

// File: sim.f
ctrlPkg.sv
execDecoder.sv
sequenceDecoder.sv
decodeStage.sv
controlUnit.sv
controlUnit_properties.sv
tbControlUnit.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, pass only when the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tbControlUnit -f sim.f &&
./obj_dir/VtbControlUnit | tee /dev/stderr | grep -qx "Test OK" ||
{ echo "simulation did not pass"; exit 1; }
